//--- logic/cart_pkg.sv
`default_nettype none

package cart_pkg;

  //////////////////////////////
  // Widths and mapper codes
  //////////////////////////////

  localparam int ADDR_W = 24; // Console and SRAM address width

  typedef enum logic [2:0] {
    MAP_HIROM   = 3'd0,
    MAP_LOROM   = 3'd1,
    MAP_EXHIROM = 3'd2,
    MAP_MENU    = 3'd7  // Menu ROM sits in upper SRAM
  } mapper_e;

  // Decoded target of a bus cycle
  typedef enum logic [2:0] {
    REG_NONE,
    REG_ROM,
    REG_SAVERAM,
    REG_MSU,
    REG_SRTC
  } region_e;

  //////////////////////////////
  // Feature bits
  //////////////////////////////

  localparam int FEAT_SRTC = 2; // S-RTC register window enable
  localparam int FEAT_MSU1 = 3; // MSU1 audio register enable

  //////////////////////////////
  // SRAM layout
  //////////////////////////////

  // Save RAM lives at the top of the cartridge SRAM
  localparam logic [ADDR_W-1:0] SAVERAM_BASE      = 24'hE00000;
  localparam logic [ADDR_W-1:0] MENU_SAVERAM_BASE = 24'hFF0000;
  localparam logic [ADDR_W-1:0] MENU_ROM_BASE     = 24'hE00000;

  // HiROM save RAM window starts at xx:6000
  localparam logic [14:0] HIROM_SRAM_OFFSET = 15'h6000;

endpackage

`default_nettype wire

//--- logic/cart_stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// One request hop between two pipeline stages
interface cart_stage_if;
  import cart_pkg::*;

  logic              valid;
  logic              ready;
  region_e           region;
  logic [ADDR_W-1:0] addr;  // Console address or translated address

  // Producer side
  modport source (
    output valid,
    output region,
    output addr,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  region,
    input  addr,
    output ready
  );

endinterface

`default_nettype wire

//--- logic/cart_region_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cart_region_decode (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  cart_pkg::mapper_e         mapper,
  input  wire [7:0]                 featurebits,
  input  wire [cart_pkg::ADDR_W-1:0] saveram_mask,
  input  wire                       req_valid,
  output logic                      req_ready,
  input  wire [cart_pkg::ADDR_W-1:0] req_addr,
  cart_stage_if.source              dn
);
  import cart_pkg::*;

  logic              mapper_ok;
  logic              sram_window;
  logic              hit_msu;
  logic              hit_srtc;
  logic              hit_saveram;
  logic              hit_rom;
  region_e           region_d;
  logic              accept;
  logic              valid_q;
  region_e           region_q;
  logic [ADDR_W-1:0] addr_q;

  //////////////////////////////
  // Window matching
  //////////////////////////////

  assign hit_msu  = featurebits[FEAT_MSU1] && !req_addr[22] &&
                    ((req_addr[15:0] & 16'hfff8) == 16'h2000); // 2000-2007
  assign hit_srtc = featurebits[FEAT_SRTC] && !req_addr[22] &&
                    ((req_addr[15:0] & 16'hfffe) == 16'h2800); // 2800-2801

  always_comb begin
    case (mapper)
      MAP_HIROM, MAP_EXHIROM, MAP_MENU: begin
        mapper_ok   = 1'b1;
        // Banks 30-3f / b0-bf, offset 6000-7fff
        sram_window = !req_addr[22] && (&req_addr[21:20]) &&
                      !req_addr[15] && (&req_addr[14:13]);
      end
      MAP_LOROM: begin
        mapper_ok   = 1'b1;
        // Banks 70-7d / f0-fd, offset 0000-7fff
        sram_window = (&req_addr[22:20]) && (req_addr[19:16] < 4'he) &&
                      !req_addr[15];
      end
      default: begin
        mapper_ok   = 1'b0;
        sram_window = 1'b0;
      end
    endcase
  end

  assign hit_saveram = saveram_mask[0] && sram_window;
  assign hit_rom     = req_addr[22] || req_addr[15];

  // First match wins
  always_comb begin
    if (!mapper_ok)       region_d = REG_NONE;
    else if (hit_msu)     region_d = REG_MSU;
    else if (hit_srtc)    region_d = REG_SRTC;
    else if (hit_saveram) region_d = REG_SAVERAM;
    else if (hit_rom)     region_d = REG_ROM;
    else                  region_d = REG_NONE;
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  assign req_ready = !valid_q || dn.ready;
  assign accept    = req_valid && req_ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (req_ready) begin
      valid_q <= req_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      region_q <= region_d;
      addr_q   <= req_addr; // Raw console address goes on to translate
    end
  end

  assign dn.valid  = valid_q;
  assign dn.region = region_q;
  assign dn.addr   = addr_q;

  // Config must hold a real mapper while requests arrive
  a_mapper_legal: assert property (@(posedge CLK) disable iff (!rst_n)
    req_valid |-> mapper inside {MAP_HIROM, MAP_LOROM, MAP_EXHIROM, MAP_MENU});

  a_dn_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    dn.valid && !dn.ready |=> dn.valid && $stable(dn.region) && $stable(dn.addr));

endmodule

`default_nettype wire

//--- logic/cart_addr_translate.sv
`timescale 1ns/10ps
`default_nettype none

module cart_addr_translate (
  input  wire                        CLK,
  input  wire                        rst_n,
  input  cart_pkg::mapper_e          mapper,
  input  wire [cart_pkg::ADDR_W-1:0] saveram_mask,
  input  wire [cart_pkg::ADDR_W-1:0] rom_mask,
  cart_stage_if.sink                 up,
  cart_stage_if.source               dn
);
  import cart_pkg::*;

  logic [14:0]       sram_off;    // Offset inside the HiROM style window
  logic [ADDR_W-1:0] hi_sram;
  logic [ADDR_W-1:0] lo_sram;
  logic [ADDR_W-1:0] sram_addr;
  logic [ADDR_W-1:0] rom_addr;
  logic [ADDR_W-1:0] addr_d;
  logic              accept;
  logic              valid_q;
  region_e           region_q;
  logic [ADDR_W-1:0] addr_q;

  //////////////////////////////
  // Save RAM forms
  //////////////////////////////

  assign sram_off = up.addr[14:0] - HIROM_SRAM_OFFSET; // Wraps in 15 bits
  assign hi_sram  = {9'd0, sram_off} & saveram_mask;
  assign lo_sram  = {9'd0, up.addr[14:0]} & saveram_mask;

  always_comb begin
    case (mapper)
      MAP_HIROM, MAP_EXHIROM: sram_addr = SAVERAM_BASE + hi_sram;
      MAP_LOROM:              sram_addr = SAVERAM_BASE + lo_sram;
      MAP_MENU:               sram_addr = MENU_SAVERAM_BASE + hi_sram;
      default:                sram_addr = '0;
    endcase
  end

  //////////////////////////////
  // ROM forms
  //////////////////////////////

  always_comb begin
    case (mapper)
      MAP_HIROM:   rom_addr = {1'b0, up.addr[22:0]} & rom_mask;
      MAP_LOROM:   rom_addr = {2'b00, up.addr[22:16], up.addr[14:0]} & rom_mask;
      // Upper 32 Mbit half of a 64 Mbit image comes from banks 40-7d
      MAP_EXHIROM: rom_addr = {1'b0, ~up.addr[23], up.addr[21:0]} & rom_mask;
      MAP_MENU:    rom_addr = ({1'b0, up.addr[22:0]} & rom_mask) + MENU_ROM_BASE;
      default:     rom_addr = '0;
    endcase
  end

  always_comb begin
    case (up.region)
      REG_SAVERAM: addr_d = sram_addr;
      REG_ROM:     addr_d = rom_addr;
      REG_MSU:     addr_d = {21'd0, up.addr[2:0]}; // MSU register index
      REG_SRTC:    addr_d = {23'd0, up.addr[0]};
      default:     addr_d = '0;
    endcase
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  assign up.ready = !valid_q || dn.ready;
  assign accept   = up.valid && up.ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (up.ready) begin
      valid_q <= up.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      region_q <= up.region;  // Region is not altered here
      addr_q   <= addr_d;
    end
  end

  assign dn.valid  = valid_q;
  assign dn.region = region_q;
  assign dn.addr   = addr_q;

  a_dn_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    dn.valid && !dn.ready |=> dn.valid && $stable(dn.region) && $stable(dn.addr));

endmodule

`default_nettype wire

//--- logic/cart_bus_result.sv
`timescale 1ns/10ps
`default_nettype none

module cart_bus_result (
  input  wire                        CLK,
  input  wire                        rst_n,
  cart_stage_if.sink                 up,
  output logic                       out_valid,
  input  wire                        out_ready,
  output logic [cart_pkg::ADDR_W-1:0] mem_addr,
  output logic                       rom_sel,
  output logic                       saveram_sel,
  output logic                       msu_sel,
  output logic                       srtc_sel
);
  import cart_pkg::*;

  logic              accept;
  logic              valid_q;
  region_e           region_q;
  logic [ADDR_W-1:0] addr_q;

  //////////////////////////////
  // Output register
  //////////////////////////////

  assign up.ready = !valid_q || out_ready;
  assign accept   = up.valid && up.ready;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (up.ready) begin
      valid_q <= up.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      region_q <= up.region;
      addr_q   <= up.addr;
    end
  end

  assign out_valid = valid_q;
  assign mem_addr  = addr_q;

  // Selects only while a result is presented
  assign rom_sel     = valid_q && (region_q == REG_ROM);
  assign saveram_sel = valid_q && (region_q == REG_SAVERAM);
  assign msu_sel     = valid_q && (region_q == REG_MSU);
  assign srtc_sel    = valid_q && (region_q == REG_SRTC);

  a_sel_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
    $onehot0({rom_sel, saveram_sel, msu_sel, srtc_sel}));

endmodule

`default_nettype wire

//--- logic/cart_mapper_top.sv
`timescale 1ns/10ps
`default_nettype none

module cart_mapper_top (
  input  wire                         CLK,
  input  wire                         rst_n,
  input  cart_pkg::mapper_e           mapper,
  input  wire [7:0]                   featurebits,
  input  wire [cart_pkg::ADDR_W-1:0]  saveram_mask,
  input  wire [cart_pkg::ADDR_W-1:0]  rom_mask,
  input  wire                         req_valid,
  output logic                        req_ready,
  input  wire [cart_pkg::ADDR_W-1:0]  req_addr,
  output logic                        out_valid,
  input  wire                         out_ready,
  output logic [cart_pkg::ADDR_W-1:0] mem_addr,
  output logic                        rom_sel,
  output logic                        saveram_sel,
  output logic                        msu_sel,
  output logic                        srtc_sel
);

  cart_stage_if dec_if ();  // Decode to translate
  cart_stage_if xlt_if ();  // Translate to result

  cart_region_decode u_decode (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .saveram_mask (saveram_mask),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_addr     (req_addr),
    .dn           (dec_if.source)
  );

  cart_addr_translate u_translate (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .mapper       (mapper),
    .saveram_mask (saveram_mask),
    .rom_mask     (rom_mask),
    .up           (dec_if.sink),
    .dn           (xlt_if.source)
  );

  cart_bus_result u_result (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .up          (xlt_if.sink),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .mem_addr    (mem_addr),
    .rom_sel     (rom_sel),
    .saveram_sel (saveram_sel),
    .msu_sel     (msu_sel),
    .srtc_sel    (srtc_sel)
  );

endmodule

`default_nettype wire

//--- bench/cart_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cart_checker (
  input  wire        CLK,
  input  wire        rst_n,
  input  wire [2:0]  mapper,
  input  wire [7:0]  featurebits,
  input  wire [23:0] saveram_mask,
  input  wire [23:0] rom_mask,
  input  wire        req_valid,
  input  wire        req_ready,
  input  wire [23:0] req_addr,
  input  wire        out_valid,
  input  wire        out_ready,
  input  wire [23:0] mem_addr,
  input  wire        rom_sel,
  input  wire        saveram_sel,
  input  wire        msu_sel,
  input  wire        srtc_sel,
  input  wire        strict_latency, // out_ready held high for the whole phase
  output int         mismatch_count,
  output int         other_count,
  output int         checked_count,
  output int         pending
);
  import cart_pkg::*;

  region_e     exp_region_q[$];
  logic [23:0] exp_addr_q[$];
  int          accept_cycle_q[$];
  int          cycle;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic region_e model_region(mapper_e m, logic [7:0] fb, logic [23:0] sm,
                                           logic [23:0] a);
    logic [15:0] lo;
    logic        sram;
    lo = a[15:0];
    if (!(m inside {MAP_HIROM, MAP_LOROM, MAP_EXHIROM, MAP_MENU})) return REG_NONE;
    if (fb[FEAT_MSU1] && !a[22] && lo >= 16'h2000 && lo <= 16'h2007) return REG_MSU;
    if (fb[FEAT_SRTC] && !a[22] && (lo == 16'h2800 || lo == 16'h2801)) return REG_SRTC;
    if (m == MAP_LOROM)
      sram = (a[22:20] == 3'b111) && (a[19:16] < 4'd14) && !a[15];
    else
      sram = !a[22] && (a[21:20] == 2'b11) && !a[15] && (a[14:13] == 2'b11);
    if (sm[0] && sram) return REG_SAVERAM;
    if (a[22] || a[15]) return REG_ROM;
    return REG_NONE;
  endfunction

  function automatic logic [23:0] model_addr(mapper_e m, region_e r, logic [23:0] sm,
                                             logic [23:0] rm, logic [23:0] a);
    logic [14:0] off;
    off = a[14:0] - 15'h6000; // Window offset, wraps like the bus
    case (r)
      REG_SAVERAM: begin
        if (m == MAP_LOROM) return SAVERAM_BASE + ({9'd0, a[14:0]} & sm);
        if (m == MAP_MENU)  return MENU_SAVERAM_BASE + ({9'd0, off} & sm);
        return SAVERAM_BASE + ({9'd0, off} & sm);
      end
      REG_ROM: begin
        if (m == MAP_LOROM)   return {2'b00, a[22:16], a[14:0]} & rm;
        if (m == MAP_EXHIROM) return {1'b0, ~a[23], a[21:0]} & rm; // Bank inversion
        if (m == MAP_MENU)    return ({1'b0, a[22:0]} & rm) + MENU_ROM_BASE;
        return {1'b0, a[22:0]} & rm;
      end
      REG_MSU:  return {21'd0, a[2:0]};
      REG_SRTC: return {23'd0, a[0]};
      default:  return 24'd0;
    endcase
  endfunction

  // Order is rom, saveram, msu, srtc
  function automatic logic [3:0] sel_vector(region_e r);
    case (r)
      REG_ROM:     return 4'b1000;
      REG_SAVERAM: return 4'b0100;
      REG_MSU:     return 4'b0010;
      REG_SRTC:    return 4'b0001;
      default:     return 4'b0000;
    endcase
  endfunction

  initial begin
    mismatch_count = 0;
    other_count    = 0;
    checked_count  = 0;
    pending        = 0;
    cycle          = 0;
  end

  //////////////////////////////
  // Per-edge comparison
  //////////////////////////////

  always @(posedge CLK) begin : check_edge
    region_e     exp_region;
    logic [23:0] exp_addr;
    int          latency;
    logic [3:0]  sels;
    sels = {rom_sel, saveram_sel, msu_sel, srtc_sel};
    cycle++;
    if (!rst_n) begin
      if (out_valid || sels != 4'b0000) begin
        $display("Mismatch at %0t: out_valid/selects in reset expected 0/0000 actual %b/%b",
                 $time, out_valid, sels);
        mismatch_count++;
      end
    end else begin
      if (out_valid && out_ready) begin
        if (exp_addr_q.size() == 0) begin
          $display("Result handed out at %0t with no request outstanding", $time);
          other_count++;
        end else begin
          exp_region = exp_region_q.pop_front();
          exp_addr   = exp_addr_q.pop_front();
          latency    = cycle - accept_cycle_q.pop_front();
          checked_count++;
          if (mem_addr !== exp_addr) begin
            $display("Mismatch at %0t: mem_addr expected %06h actual %06h",
                     $time, exp_addr, mem_addr);
            mismatch_count++;
          end
          if (sels !== sel_vector(exp_region)) begin
            $display("Mismatch at %0t: selects expected %b actual %b",
                     $time, sel_vector(exp_region), sels);
            mismatch_count++;
          end
          if (latency < 3 || (strict_latency && latency != 3)) begin
            $display("Mismatch at %0t: latency expected 3 actual %0d", $time, latency);
            mismatch_count++;
          end
        end
      end else if (!out_valid && sels != 4'b0000) begin
        $display("Mismatch at %0t: selects expected 0000 actual %b", $time, sels);
        mismatch_count++;
      end
      // Full throughput expected while nothing pushes back
      if (strict_latency && req_valid && !req_ready) begin
        $display("Mismatch at %0t: req_ready expected 1 actual 0", $time);
        mismatch_count++;
      end
      if (req_valid && req_ready) begin
        exp_region = model_region(mapper_e'(mapper), featurebits, saveram_mask, req_addr);
        exp_region_q.push_back(exp_region);
        exp_addr_q.push_back(model_addr(mapper_e'(mapper), exp_region, saveram_mask,
                                        rom_mask, req_addr));
        accept_cycle_q.push_back(cycle);
      end
    end
    pending <= exp_addr_q.size(); // Seen by the bench one edge later
  end

endmodule

`default_nettype wire

//--- bench/cart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cart_tb;
  import cart_pkg::*;

  localparam int PHASE_CYCLES = 150;
  localparam int DRAIN_LIMIT  = 40;   // Cycles allowed to empty the pipeline

  logic        CLK;
  logic        rst_n;
  mapper_e     mapper;
  logic [7:0]  featurebits;
  logic [23:0] saveram_mask;
  logic [23:0] rom_mask;
  logic        req_valid;
  logic        req_ready;
  logic [23:0] req_addr;
  logic        out_valid;
  logic        out_ready;
  logic [23:0] mem_addr;
  logic        rom_sel;
  logic        saveram_sel;
  logic        msu_sel;
  logic        srtc_sel;
  logic        strict_latency;
  logic        timed_out;
  logic [31:0] seed;
  int          mismatch_count;
  int          other_count;
  int          checked_count;
  int          pending;

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  cart_mapper_top u_dut (
    .CLK (CLK), .rst_n (rst_n), .mapper (mapper), .featurebits (featurebits),
    .saveram_mask (saveram_mask), .rom_mask (rom_mask),
    .req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
    .out_valid (out_valid), .out_ready (out_ready), .mem_addr (mem_addr),
    .rom_sel (rom_sel), .saveram_sel (saveram_sel), .msu_sel (msu_sel), .srtc_sel (srtc_sel)
  );

  cart_checker u_check (
    .CLK (CLK), .rst_n (rst_n), .mapper (mapper), .featurebits (featurebits),
    .saveram_mask (saveram_mask), .rom_mask (rom_mask),
    .req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
    .out_valid (out_valid), .out_ready (out_ready), .mem_addr (mem_addr),
    .rom_sel (rom_sel), .saveram_sel (saveram_sel), .msu_sel (msu_sel), .srtc_sel (srtc_sel),
    .strict_latency (strict_latency), .mismatch_count (mismatch_count),
    .other_count (other_count), .checked_count (checked_count), .pending (pending)
  );

  //////////////////////////////
  // Random source
  //////////////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic draw(output logic [31:0] r);
    seed = lcg_next(seed);
    r    = seed ^ {seed[15:0], seed[31:16]}; // Fold weak low bits with the high half
  endtask

  // About half the addresses land in a peripheral or save RAM window
  task automatic pick_addr(output logic [23:0] a);
    logic [31:0] r;
    logic [31:0] b;
    draw(r);
    draw(b);
    if (!r[3]) a = b[23:0];
    else case (r[2:0])
      // Random bit 22 moves these offsets out to ROM
      3'd0, 3'd1: a = {b[23:16], 16'h2000 + {12'd0, r[7:4]}};
      3'd2:       a = {b[23:16], 16'h2800 + {14'd0, r[5:4]}};
      3'd3, 3'd4: a = {b[23], 1'b0, 2'b11, b[19:16], 1'b0, 2'b11, b[12:0]};
      default:    a = {b[23], 3'b111, b[19:16], 1'b0, b[14:0]};
    endcase
  endtask

  //////////////////////////////
  // Phase sequencing
  //////////////////////////////

  task automatic set_config(input int phase);
    logic [31:0] r;
    draw(r);
    case (phase)
      0:       mapper <= MAP_HIROM;
      1, 5:    mapper <= MAP_LOROM;
      2:       mapper <= MAP_EXHIROM;
      3:       mapper <= MAP_MENU;
      default: mapper <= MAP_HIROM;
    endcase
    featurebits <= (phase == 4) ? 8'h00 : {r[7:4], 2'b11, r[1:0]};
    draw(r);
    saveram_mask <= (phase == 4) ? (r[23:0] & ~24'h1) : (r[23:0] | 24'h1);
    draw(r);
    rom_mask       <= r[23:0];
    strict_latency <= (phase == 5);
  endtask

  task automatic run_traffic(input logic hold_ready);
    logic [31:0] r;
    logic [23:0] a;
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      @(posedge CLK);
      draw(r);
      if (!(req_valid && !req_ready)) begin // Hold a stalled request
        pick_addr(a);
        req_valid <= hold_ready || (r[1:0] != 2'b00);
        req_addr  <= a;
      end
      out_ready <= hold_ready || (r[5:4] != 2'b00);
    end
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    do begin
      @(posedge CLK);
      if (!(req_valid && !req_ready)) req_valid <= 1'b0;
      out_ready <= 1'b1;
      waited++;
    end while ((req_valid || pending != 0 || out_valid) && waited < DRAIN_LIMIT);
    if (req_valid || pending != 0 || out_valid) begin
      $display("Pipeline did not drain within %0d cycles, %0d requests still inside",
               DRAIN_LIMIT, pending);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    mapper         = MAP_HIROM;
    featurebits    = 8'h00;
    saveram_mask   = 24'h0;
    rom_mask       = 24'h0;
    req_valid      = 1'b0;
    req_addr       = 24'h0;
    out_ready      = 1'b0;
    strict_latency = 1'b0;
    timed_out      = 1'b0;
    seed           = 32'h6c7a;
    repeat (8) @(posedge CLK);
    rst_n <= 1'b1;
    // HiROM, LoROM, ExHiROM, menu, gated features, then full rate
    for (int phase = 0; phase < 6 && !timed_out; phase++) begin
      set_config(phase);
      run_traffic(phase == 5);
      drain();
    end
    $display("Checked %0d results, %0d mismatches, %0d other errors",
             checked_count, mismatch_count, other_count);
    if (timed_out || mismatch_count != 0 || other_count != 0)
      $display("TB FAILED");
    else
      $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
logic/cart_pkg.sv
logic/cart_stage_if.sv
logic/cart_region_decode.sv
logic/cart_addr_translate.sv
logic/cart_bus_result.sv
logic/cart_mapper_top.sv
bench/cart_checker.sv
bench/cart_tb.sv
